// ==== verilog.f ====
+incdir+.
bubble_pkg.sv
game_control.sv
level_roster.sv
scene_sequencer.sv
sprite_raster.sv
bubble_top.sv
tb_clock.sv
tb_bubble.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_bubble
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_scene_model.svh ====
// Reference model for the game core testbench
// Game-state step, level-to-mask lookup and the expected pixel stream
`ifndef TB_SCENE_MODEL_SVH
`define TB_SCENE_MODEL_SVH

    localparam int ST_SELECT     = 0;
    localparam int ST_LOAD       = 1;
    localparam int ST_PAUSE      = 2;
    localparam int ST_PLAY_START = 3;
    localparam int ST_PLAY       = 4;
    localparam int ST_PAUSING    = 5;
    localparam int ST_OVER       = 6;
    localparam int NUM_SLOTS     = ENEMY_COUNT_MAX + 3;  // Erase, player, enemies, bullet

    // Scene captured for the frame under test
    logic                       scene_erase;
    int                         scene_px;
    int                         scene_py;
    int                         scene_bx;
    int                         scene_by;
    logic                       scene_bullet;
    logic [ENEMY_COUNT_MAX-1:0] scene_alive;

    function automatic int next_game_state(int s, logic go_in, logic hit_in, logic dead_in);
        case (s)
            ST_SELECT:     return go_in ? ST_LOAD : s;
            ST_LOAD:       return go_in ? s : ST_PAUSE;
            ST_PAUSE:      return go_in ? ST_PLAY_START : s;
            ST_PLAY_START: return go_in ? s : ST_PLAY;
            ST_PLAY: begin
                if (go_in) return ST_PAUSING;
                if (hit_in || dead_in) return ST_OVER;
                return s;
            end
            ST_PAUSING:    return go_in ? s : ST_PAUSE;
            ST_OVER:       return go_in ? ST_LOAD : s;
            default:       return ST_SELECT;
        endcase
    endfunction

    // playing, paused, game_over
    function automatic logic [2:0] state_flags(int s);
        return {s == ST_PLAY, s == ST_PAUSE, s == ST_OVER};
    endfunction

    function automatic logic [ENEMY_COUNT_MAX-1:0] mask_for_level(int lvl);
        case (lvl)
            2:       return 5'b00111;
            3:       return 5'b11000;
            4:       return 5'b11111;
            default: return 5'b00011;  // Level 1 and unknown levels
        endcase
    endfunction

    // Part of a span that lies before the screen edge
    function automatic int span_on_screen(int start, int len, int limit);
        if (start >= limit) return 0;
        return (start + len > limit) ? limit - start : len;
    endfunction

    function automatic bit slot_rect(int slot, output int x, output int y, output int w,
                                     output int h, output int c);
        int e;
        e = slot - 2;
        x = 0;
        y = 0;
        w = SCREEN_W;
        h = SCREEN_H;
        c = int'(BG_COLOR);
        if (slot == 0) return scene_erase == 1'b1;
        if (slot == 1) begin
            x = scene_px;
            y = scene_py;
            w = PLAYER_WIDTH;
            h = PLAYER_WIDTH;
            c = int'(PLAYER_COLOR);
            return 1'b1;
        end
        if (e < ENEMY_COUNT_MAX) begin
            x = int'(ENEMY_X[e]);
            y = int'(ENEMY_Y[e]);
            w = int'(ENEMY_WIDTH[e]);
            h = int'(ENEMY_WIDTH[e]);
            c = int'(ENEMY_COLOR[e]);
            return scene_alive[e] == 1'b1;
        end
        x = scene_bx;
        y = scene_by;
        w = 1;
        h = 1;
        c = int'(BULLET_COLOR);
        return scene_bullet == 1'b1;
    endfunction

    function automatic int frame_pixel_total();
        int total;
        int x;
        int y;
        int w;
        int h;
        int c;
        total = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (slot_rect(s, x, y, w, h, c)) begin
                total += span_on_screen(x, w, SCREEN_W) * span_on_screen(y, h, SCREEN_H);
            end
        end
        return total;
    endfunction

    // Pixel n of the frame, row by row within each sprite
    function automatic bit expected_pixel(int n, output int ex, output int ey, output int ec);
        int x;
        int y;
        int w;
        int h;
        int c;
        int vw;
        int rest;
        rest = n;
        ex = 0;
        ey = 0;
        ec = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (slot_rect(s, x, y, w, h, c)) begin
                vw = span_on_screen(x, w, SCREEN_W);
                if (rest < vw * span_on_screen(y, h, SCREEN_H)) begin
                    ex = x + rest % vw;
                    ey = y + rest / vw;
                    ec = c;
                    return 1'b1;
                end
                rest -= vw * span_on_screen(y, h, SCREEN_H);
            end
        end
        return 1'b0;
    endfunction

`endif

// ==== tb_bubble.sv ====
// Testbench top for the game core
// Runs game states, level loads, hits and two frames, and checks the
// flags and the pixel stream against the reference model
module tb_bubble import bubble_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 100000;  // Erase frame under stalls needs about 40000

    logic                       clk;
    logic                       resetn;
    logic                       restart;
    logic                       go;
    logic [LEVEL_BITS-1:0]      level;
    logic                       player_hit;
    logic                       bullet_hit;
    logic [2:0]                 hit_index;
    logic [X_BITS-1:0]          player_x;
    logic [Y_BITS-1:0]          player_y;
    logic [X_BITS-1:0]          bullet_x;
    logic [Y_BITS-1:0]          bullet_y;
    logic                       bullet_active;
    logic                       frame_valid;
    logic                       frame_erase;
    logic                       frame_ready;
    logic                       pixel_valid;
    logic                       pixel_ready = 1'b1;
    logic [X_BITS-1:0]          pixel_x;
    logic [Y_BITS-1:0]          pixel_y;
    logic [COLOR_BITS-1:0]      pixel_color;
    logic                       frame_done;
    logic                       playing;
    logic                       paused;
    logic                       game_over;
    logic [ENEMY_COUNT_MAX-1:0] enemies_alive;

    integer                     seed = 32'h2cba_6f6a;
    int                         cycles = 0;
    int                         err_main = 0;
    int                         err_state = 0;
    int                         err_pix = 0;
    int                         test_start_errors;
    int                         tests_run;
    int                         tests_failed;
    string                      test_name;
    logic                       checking;
    logic                       rand_ready;
    int                         pix_count = 0;
    logic                       done_seen = 1'b0;
    int                         m_state = 0;
    logic [ENEMY_COUNT_MAX-1:0] m_mask = '0;
    logic [ENEMY_COUNT_MAX-1:0] m_alive = '0;
    logic                       m_hit_prev = 1'b0;

    `include "tb_scene_model.svh"

    tb_clock u_clock (.restart, .clk, .resetn);

    bubble_top u_dut (
        .clk, .resetn, .go, .level, .player_hit, .bullet_hit, .hit_index,
        .player_x, .player_y, .bullet_x, .bullet_y, .bullet_active,
        .frame_valid, .frame_erase, .frame_ready, .pixel_valid, .pixel_ready,
        .pixel_x, .pixel_y, .pixel_color, .frame_done, .playing, .paused,
        .game_over, .enemies_alive
    );

    // Reference game state and roster, compared every cycle
    always @(posedge clk) begin
        if (!resetn) begin
            m_state    <= ST_SELECT;
            m_mask     <= '0;
            m_alive    <= '0;
            m_hit_prev <= 1'b0;
        end else begin
            assert ({playing, paused, game_over} == state_flags(m_state))
            else begin
                $display("CHECK FAILED %s flags: expected %b actual %b", test_name,
                         state_flags(m_state), {playing, paused, game_over});
                err_state++;
            end
            assert (enemies_alive == m_alive)
            else begin
                $display("CHECK FAILED %s enemies_alive: expected %b actual %b", test_name,
                         m_alive, enemies_alive);
                err_state++;
            end
            m_hit_prev <= bullet_hit;
            if (m_state == ST_SELECT) begin
                m_mask <= mask_for_level(int'(level));
            end
            if (m_state == ST_LOAD) begin
                m_alive <= m_mask;
            end else if (m_state == ST_PLAY && bullet_hit && !m_hit_prev
                         && int'(hit_index) < ENEMY_COUNT_MAX) begin
                m_alive[hit_index] <= 1'b0;  // Rising edge only
            end
            m_state <= next_game_state(m_state, go, player_hit, m_alive == '0);
        end
    end

    always @(posedge clk) begin : drive_stalls
        int r;
        r = $random(seed);
        pixel_ready <= rand_ready ? r[0] : 1'b1;
    end

    always @(posedge clk) begin : compare_pixels
        int ex;
        int ey;
        int ec;
        if (resetn && frame_valid && frame_ready) begin
            pix_count <= 0;  // New frame accepted
            done_seen <= 1'b0;
        end else if (resetn && checking) begin
            if (pixel_valid && pixel_ready) begin
                if (!expected_pixel(pix_count, ex, ey, ec)) begin
                    $display("%s: pixel %0d arrived after the end of the expected frame",
                             test_name, pix_count);
                    err_pix++;
                end else begin
                    assert (int'(pixel_x) == ex && int'(pixel_y) == ey
                            && int'(pixel_color) == ec)
                    else begin
                        $display("CHECK FAILED %s pixel %0d: expected %0d,%0d,%0d actual %0d,%0d,%0d",
                                 test_name, pix_count, ex, ey, ec, pixel_x, pixel_y, pixel_color);
                        err_pix++;
                    end
                end
                pix_count <= pix_count + 1;
            end
            if (frame_done) begin
                done_seen <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in test %s, the DUT stopped responding",
                     cycles, test_name);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int error_total();
        return err_main + err_state + err_pix;
    endfunction

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual)
        else begin
            $display("CHECK FAILED %s %s: expected 'h%0h actual 'h%0h", test_name, what,
                     expected, actual);
            err_main++;
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_start_errors = error_total();
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_total() == test_start_errors) begin
            $display("%-12s pass", test_name);
        end else begin
            $display("%-12s fail, %0d errors", test_name, error_total() - test_start_errors);
            tests_failed++;
        end
    endtask

    // Reset pulse through the clock generator
    task automatic reset_dut();
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic press_go();
        @(posedge clk);
        go <= 1'b1;
        repeat (3) @(posedge clk);
        go <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic wait_game_over();
        while (game_over !== 1'b1) @(posedge clk);
    endtask

    task automatic run_frame(logic erase, int px, int py, int bx, int by, logic bact,
                             logic stall);
        int total;
        scene_erase  = erase;
        scene_px     = px;
        scene_py     = py;
        scene_bx     = bx;
        scene_by     = by;
        scene_bullet = bact;
        scene_alive  = m_alive;
        total        = frame_pixel_total();
        frame_erase   <= erase;
        player_x      <= X_BITS'(px);
        player_y      <= Y_BITS'(py);
        bullet_x      <= X_BITS'(bx);
        bullet_y      <= Y_BITS'(by);
        bullet_active <= bact;
        rand_ready    <= stall;
        checking      <= 1'b1;
        frame_valid   <= 1'b1;
        @(posedge clk);
        while (frame_ready !== 1'b1) @(posedge clk);
        frame_valid <= 1'b0;
        @(posedge clk);
        while (!done_seen) @(posedge clk);
        check_value("pixel count", total, pix_count);
        check_value("frame_ready", 1, int'(frame_ready));
        checking   <= 1'b0;
        rand_ready <= 1'b0;
    endtask

    initial begin
        int levels [6] = '{0, 1, 2, 3, 4, 7};
        int kill_order [4] = '{0, 1, 3, 4};
        test_name     = "reset";
        tests_run     = 0;
        tests_failed  = 0;
        restart       <= 1'b0;
        go            <= 1'b0;
        level         <= '0;
        player_hit    <= 1'b0;
        bullet_hit    <= 1'b0;
        hit_index     <= '0;
        player_x      <= '0;
        player_y      <= '0;
        bullet_x      <= '0;
        bullet_y      <= '0;
        bullet_active <= 1'b0;
        frame_valid   <= 1'b0;
        frame_erase   <= 1'b0;
        checking      <= 1'b0;
        rand_ready    <= 1'b0;
        repeat (3) @(posedge clk);

        begin_test("game_states");
        press_go();  // Select, load, pause
        press_go();  // Play
        press_go();  // Pausing, back to pause
        press_go();
        check_value("playing", 1, int'(playing));
        finish_test();

        begin_test("level_masks");
        foreach (levels[i]) begin
            reset_dut();
            level <= LEVEL_BITS'(levels[i]);
            press_go();
            check_value($sformatf("level %0d mask", levels[i]),
                        int'(mask_for_level(levels[i])), int'(enemies_alive));
        end
        finish_test();

        begin_test("held_hit");
        reset_dut();
        level <= 3'd4;
        press_go();
        press_go();
        bullet_hit <= 1'b1;
        hit_index  <= 3'd2;
        @(posedge clk);
        hit_index  <= 3'd3;  // Index moves while the hit stays high
        repeat (4) @(posedge clk);
        bullet_hit <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("enemies_alive", int'(mask_for_level(4) & ~5'b00100), int'(enemies_alive));
        finish_test();

        begin_test("kill_all");
        foreach (kill_order[i]) begin
            bullet_hit <= 1'b1;
            hit_index  <= 3'(kill_order[i]);
            @(posedge clk);
            bullet_hit <= 1'b0;
            @(posedge clk);
        end
        wait_game_over();
        check_value("enemies_alive", 0, int'(enemies_alive));
        finish_test();

        begin_test("player_hit");
        reset_dut();
        level <= 3'd1;
        press_go();
        press_go();
        player_hit <= 1'b1;
        @(posedge clk);
        player_hit <= 1'b0;
        wait_game_over();
        check_value("enemies_alive", int'(mask_for_level(1)), int'(enemies_alive));
        finish_test();

        begin_test("frame_plain");
        reset_dut();
        level <= 3'd4;
        press_go();
        run_frame(1'b0, 10, 10, 40, 40, 1'b1, 1'b0);
        finish_test();

        begin_test("frame_erase");
        run_frame(1'b1, 158, 60, 200, 10, 1'b1, 1'b1);  // Player clipped, bullet off screen
        finish_test();

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset
// 20 ns clock, reset held low for two cycles at start and on request
module tb_clock (
    input  logic restart,
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    int   hold = 2;
    logic rst_n = 1'b0;

    assign resetn = rst_n;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (restart) begin
            hold  <= 2;
            rst_n <= 1'b0;
        end else if (hold > 1) begin
            hold <= hold - 1;
        end else begin
            hold  <= 0;
            rst_n <= 1'b1;  // Low for two edges
        end
    end

endmodule

// ==== bubble_top.sv ====
// Game core top level
// Game-state FSM, level roster and the two-stage frame renderer
module bubble_top import bubble_pkg::*; #(
    parameter int SCREEN_W    = bubble_pkg::SCREEN_W,
    parameter int SCREEN_H    = bubble_pkg::SCREEN_H,
    parameter int NUM_ENEMIES = ENEMY_COUNT_MAX,
    localparam int IDX_BITS = (NUM_ENEMIES > 1) ? $clog2(NUM_ENEMIES) : 1
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   go,
    input  logic [LEVEL_BITS-1:0]  level,
    input  logic                   player_hit,
    input  logic                   bullet_hit,
    input  logic [IDX_BITS-1:0]    hit_index,
    input  logic [X_BITS-1:0]      player_x,
    input  logic [Y_BITS-1:0]      player_y,
    input  logic [X_BITS-1:0]      bullet_x,
    input  logic [Y_BITS-1:0]      bullet_y,
    input  logic                   bullet_active,
    input  logic                   frame_valid,
    input  logic                   frame_erase,
    output logic                   frame_ready,
    output logic                   pixel_valid,
    input  logic                   pixel_ready,
    output logic [X_BITS-1:0]      pixel_x,
    output logic [Y_BITS-1:0]      pixel_y,
    output logic [COLOR_BITS-1:0]  pixel_color,
    output logic                   frame_done,
    output logic                   playing,
    output logic                   paused,
    output logic                   game_over,
    output logic [NUM_ENEMIES-1:0] enemies_alive
);

    logic                  selecting;
    logic                  load_level;
    logic                  enemies_dead;
    logic                  desc_valid;
    logic                  desc_ready;
    logic [X_BITS-1:0]     desc_x;
    logic [Y_BITS-1:0]     desc_y;
    logic [X_BITS-1:0]     desc_w;
    logic [Y_BITS-1:0]     desc_h;
    logic [COLOR_BITS-1:0] desc_color;
    logic                  desc_last;

    game_control u_control (
        .clk, .resetn, .go, .player_hit, .enemies_dead,
        .selecting, .load_level, .paused, .playing, .game_over
    );

    level_roster #(
        .NUM_ENEMIES(NUM_ENEMIES)
    ) u_roster (
        .clk, .resetn, .level, .selecting, .load_level, .playing,
        .bullet_hit, .hit_index, .enemies_alive, .enemies_dead
    );

    scene_sequencer #(
        .NUM_ENEMIES(NUM_ENEMIES),
        .SCREEN_W(SCREEN_W),
        .SCREEN_H(SCREEN_H)
    ) u_sequencer (
        .clk, .resetn, .frame_valid, .frame_erase, .frame_ready,
        .player_x, .player_y, .bullet_x, .bullet_y, .bullet_active,
        .enemies_alive, .desc_valid, .desc_ready, .desc_x, .desc_y,
        .desc_w, .desc_h, .desc_color, .desc_last, .frame_done
    );

    sprite_raster #(
        .SCREEN_W(SCREEN_W),
        .SCREEN_H(SCREEN_H)
    ) u_raster (
        .clk, .resetn, .desc_valid, .desc_ready, .desc_x, .desc_y,
        .desc_w, .desc_h, .desc_color, .desc_last,
        .pixel_valid, .pixel_ready, .pixel_x, .pixel_y, .pixel_color,
        .frame_done
    );

endmodule

// ==== sprite_raster.sv ====
// Second render stage
// Expands rectangle descriptors into pixel writes, row by row,
// skipping off-screen pixels and holding under back-pressure
module sprite_raster import bubble_pkg::*; #(
    parameter int SCREEN_W = bubble_pkg::SCREEN_W,
    parameter int SCREEN_H = bubble_pkg::SCREEN_H
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  desc_valid,
    output logic                  desc_ready,
    input  logic [X_BITS-1:0]     desc_x,
    input  logic [Y_BITS-1:0]     desc_y,
    input  logic [X_BITS-1:0]     desc_w,
    input  logic [Y_BITS-1:0]     desc_h,
    input  logic [COLOR_BITS-1:0] desc_color,
    input  logic                  desc_last,
    output logic                  pixel_valid,
    input  logic                  pixel_ready,
    output logic [X_BITS-1:0]     pixel_x,
    output logic [Y_BITS-1:0]     pixel_y,
    output logic [COLOR_BITS-1:0] pixel_color,
    output logic                  frame_done
);

    logic                  active;
    logic [X_BITS-1:0]     base_x;
    logic [Y_BITS-1:0]     base_y;
    logic [X_BITS-1:0]     rect_w;
    logic [Y_BITS-1:0]     rect_h;
    logic [COLOR_BITS-1:0] rect_color;
    logic                  rect_last;
    logic [X_BITS-1:0]     off_x;
    logic [Y_BITS-1:0]     off_y;
    logic [X_BITS:0]       abs_x;   // One spare bit past the right edge
    logic [Y_BITS:0]       abs_y;
    logic                  on_screen;
    logic                  step;
    logic                  at_end;
    logic                  row_end;

    assign abs_x     = {1'b0, base_x} + {1'b0, off_x};
    assign abs_y     = {1'b0, base_y} + {1'b0, off_y};
    assign on_screen = (abs_x < SCREEN_W) && (abs_y < SCREEN_H);

    assign pixel_valid = active && on_screen;
    assign pixel_x     = abs_x[X_BITS-1:0];
    assign pixel_y     = abs_y[Y_BITS-1:0];
    assign pixel_color = rect_color;

    // Clipped pixels advance without waiting for the sink
    assign step       = active && (!on_screen || pixel_ready);
    assign row_end    = (off_x == rect_w - 1'b1);
    assign at_end     = row_end && (off_y == rect_h - 1'b1);
    assign desc_ready = !active || (step && at_end);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= step && at_end && rect_last;
            if (desc_valid && desc_ready) begin
                active <= 1'b1;
            end else if (step && at_end) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc_valid && desc_ready) begin
            base_x     <= desc_x;
            base_y     <= desc_y;
            rect_w     <= desc_w;
            rect_h     <= desc_h;
            rect_color <= desc_color;
            rect_last  <= desc_last;
            off_x      <= '0;
            off_y      <= '0;
        end else if (step) begin
            if (row_end) begin
                off_x <= '0;
                off_y <= off_y + 1'b1;
            end else begin
                off_x <= off_x + 1'b1;
            end
        end
    end

    a_pixel_hold: assert property (
        @(posedge clk) disable iff (!resetn)
        pixel_valid && !pixel_ready |=> pixel_valid &&
            $stable({pixel_x, pixel_y, pixel_color})
    );

endmodule

// ==== scene_sequencer.sv ====
// First render stage
// Captures the scene on frame acceptance and issues one rectangle
// descriptor per sprite: erase, player, live enemies, bullet
module scene_sequencer import bubble_pkg::*; #(
    parameter int NUM_ENEMIES = ENEMY_COUNT_MAX,
    parameter int SCREEN_W    = bubble_pkg::SCREEN_W,
    parameter int SCREEN_H    = bubble_pkg::SCREEN_H
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   frame_valid,
    input  logic                   frame_erase,
    output logic                   frame_ready,
    input  logic [X_BITS-1:0]      player_x,
    input  logic [Y_BITS-1:0]      player_y,
    input  logic [X_BITS-1:0]      bullet_x,
    input  logic [Y_BITS-1:0]      bullet_y,
    input  logic                   bullet_active,
    input  logic [NUM_ENEMIES-1:0] enemies_alive,
    output logic                   desc_valid,
    input  logic                   desc_ready,
    output logic [X_BITS-1:0]      desc_x,
    output logic [Y_BITS-1:0]      desc_y,
    output logic [X_BITS-1:0]      desc_w,
    output logic [Y_BITS-1:0]      desc_h,
    output logic [COLOR_BITS-1:0]  desc_color,
    output logic                   desc_last,
    input  logic                   frame_done
);

    // Slot 0 erase, 1 player, 2.. enemies, last one bullet
    localparam int NSLOT     = NUM_ENEMIES + 3;
    localparam int SLOT_BITS = $clog2(NSLOT);

    logic [NSLOT-1:0]      slot_en;
    logic [NSLOT-1:0]      pending;     // Slots still to issue
    logic [NSLOT-1:0]      pending_rest;
    logic [SLOT_BITS-1:0]  next_slot;
    logic                  busy;
    logic                  accept;
    logic                  load_desc;
    logic [X_BITS-1:0]     snap_px;
    logic [Y_BITS-1:0]     snap_py;
    logic [X_BITS-1:0]     snap_bx;
    logic [Y_BITS-1:0]     snap_by;
    logic [X_BITS-1:0]     nx;
    logic [Y_BITS-1:0]     ny;
    logic [X_BITS-1:0]     nw;
    logic [Y_BITS-1:0]     nh;
    logic [COLOR_BITS-1:0] nc;

    assign frame_ready = !busy;
    assign accept      = frame_valid && frame_ready;
    assign slot_en     = {bullet_active, enemies_alive, 1'b1, frame_erase};
    assign load_desc   = (pending != '0) && (!desc_valid || desc_ready);

    // Lowest pending slot goes next
    always_comb begin
        next_slot = '0;
        for (int s = NSLOT - 1; s >= 0; s--) begin
            if (pending[s]) next_slot = SLOT_BITS'(s);
        end
        pending_rest = pending;
        pending_rest[next_slot] = 1'b0;
    end

    always_comb begin
        nx = snap_bx;  // Bullet unless another slot matches
        ny = snap_by;
        nw = X_BITS'(1);
        nh = Y_BITS'(1);
        nc = BULLET_COLOR;
        if (next_slot == '0) begin
            nx = '0;
            ny = '0;
            nw = X_BITS'(SCREEN_W);
            nh = Y_BITS'(SCREEN_H);
            nc = BG_COLOR;
        end else if (next_slot == SLOT_BITS'(1)) begin
            nx = snap_px;
            ny = snap_py;
            nw = X_BITS'(PLAYER_WIDTH);
            nh = Y_BITS'(PLAYER_WIDTH);
            nc = PLAYER_COLOR;
        end
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            if (next_slot == SLOT_BITS'(i + 2)) begin
                nx = ENEMY_X[i];
                ny = ENEMY_Y[i];
                nw = X_BITS'(ENEMY_WIDTH[i]);
                nh = Y_BITS'(ENEMY_WIDTH[i]);
                nc = ENEMY_COLOR[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy       <= 1'b0;
            pending    <= '0;
            desc_valid <= 1'b0;
        end else begin
            if (accept) begin
                busy    <= 1'b1;
                pending <= slot_en;
            end else if (load_desc) begin
                pending <= pending_rest;
            end
            if (frame_done) busy <= 1'b0;  // Raster stage drained
            if (load_desc) begin
                desc_valid <= 1'b1;
            end else if (desc_ready) begin
                desc_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            snap_px <= player_x;
            snap_py <= player_y;
            snap_bx <= bullet_x;
            snap_by <= bullet_y;
        end
        if (load_desc) begin
            desc_x     <= nx;
            desc_y     <= ny;
            desc_w     <= nw;
            desc_h     <= nh;
            desc_color <= nc;
            desc_last  <= (pending_rest == '0);
        end
    end

    a_desc_hold: assert property (
        @(posedge clk) disable iff (!resetn)
        desc_valid && !desc_ready |=> desc_valid &&
            $stable({desc_x, desc_y, desc_w, desc_h, desc_color, desc_last})
    );

endmodule

// ==== level_roster.sv ====
// Level roster
// Holds the selected level's enemy mask, loads it as the alive mask
// and removes one enemy per rising bullet hit
module level_roster import bubble_pkg::*; #(
    parameter int NUM_ENEMIES = ENEMY_COUNT_MAX,
    localparam int IDX_BITS = (NUM_ENEMIES > 1) ? $clog2(NUM_ENEMIES) : 1
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [LEVEL_BITS-1:0]  level,
    input  logic                   selecting,
    input  logic                   load_level,
    input  logic                   playing,
    input  logic                   bullet_hit,
    input  logic [IDX_BITS-1:0]    hit_index,
    output logic [NUM_ENEMIES-1:0] enemies_alive,
    output logic                   enemies_dead
);

    logic [NUM_ENEMIES-1:0] level_mask;
    logic                   hit_prev;
    logic                   hit_rise;

    assign hit_rise = bullet_hit && !hit_prev;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            level_mask    <= '0;
            enemies_alive <= '0;
            hit_prev      <= 1'b0;
        end else begin
            hit_prev <= bullet_hit;
            if (selecting) begin
                level_mask <= LEVEL_MASK[level][NUM_ENEMIES-1:0];
            end
            if (load_level) begin
                enemies_alive <= level_mask;
            end else if (playing && hit_rise && (hit_index < NUM_ENEMIES)) begin
                enemies_alive[hit_index] <= 1'b0;  // One kill per hit
            end
        end
    end

    assign enemies_dead = (enemies_alive == '0);

    // Enemies never come back outside a level load
    a_alive_in_mask: assert property (
        @(posedge clk) disable iff (!resetn)
        (enemies_alive & ~level_mask) == '0
    );

endmodule

// ==== game_control.sv ====
// Game-state FSM
// Steps through level select, load, pause and play on go press and release
// and ends play on a player hit or when no enemy is left
module game_control (
    input  logic clk,
    input  logic resetn,
    input  logic go,
    input  logic player_hit,
    input  logic enemies_dead,
    output logic selecting,
    output logic load_level,
    output logic paused,
    output logic playing,
    output logic game_over
);

    localparam logic [2:0] S_SELECT     = 3'd0;
    localparam logic [2:0] S_LOAD       = 3'd1;
    localparam logic [2:0] S_PAUSE      = 3'd2;
    localparam logic [2:0] S_PLAY_START = 3'd3;
    localparam logic [2:0] S_PLAY       = 3'd4;
    localparam logic [2:0] S_PAUSING    = 3'd5;
    localparam logic [2:0] S_OVER       = 3'd6;

    logic [2:0] state;
    logic [2:0] state_next;

    always_comb begin
        state_next = state;
        case (state)
            S_SELECT:     if (go) state_next = S_LOAD;
            S_LOAD:       if (!go) state_next = S_PAUSE;
            S_PAUSE:      if (go) state_next = S_PLAY_START;
            S_PLAY_START: if (!go) state_next = S_PLAY;
            S_PLAY: begin
                if (go) begin
                    state_next = S_PAUSING;
                end else if (player_hit || enemies_dead) begin
                    state_next = S_OVER;
                end
            end
            S_PAUSING:    if (!go) state_next = S_PAUSE;
            S_OVER:       if (go) state_next = S_LOAD;  // Restart same level
            default:      state_next = S_SELECT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_SELECT;
        end else begin
            state <= state_next;
        end
    end

    assign selecting  = (state == S_SELECT);
    assign load_level = (state == S_LOAD);
    assign paused     = (state == S_PAUSE);
    assign playing    = (state == S_PLAY);
    assign game_over  = (state == S_OVER);

    a_flags_onehot: assert property (
        @(posedge clk) disable iff (!resetn)
        $onehot0({selecting, load_level, paused, playing, game_over})
    );

endmodule

// ==== bubble_pkg.sv ====
// Shared constants for the game core
// Screen geometry, coordinate and colour widths, sprite colours,
// enemy table and level-to-enemy masks
package bubble_pkg;

    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    localparam int X_BITS     = 8;
    localparam int Y_BITS     = 7;
    localparam int COLOR_BITS = 3;
    localparam int LEVEL_BITS = 3;  // Level switch width

    localparam logic [COLOR_BITS-1:0] BG_COLOR     = 3'd0;
    localparam logic [COLOR_BITS-1:0] PLAYER_COLOR = 3'd7;
    localparam logic [COLOR_BITS-1:0] BULLET_COLOR = 3'd7;

    localparam int PLAYER_WIDTH = 3;  // Square sprite

    localparam int ENEMY_COUNT_MAX = 5;

    // Enemy table, indexed by enemy number
    localparam logic [2:0] ENEMY_WIDTH [ENEMY_COUNT_MAX] = '{
        3'd3, 3'd5, 3'd7, 3'd5, 3'd7
    };
    localparam logic [X_BITS-1:0] ENEMY_X [ENEMY_COUNT_MAX] = '{
        8'd80, 8'd100, 8'd30, 8'd50, 8'd80
    };
    localparam logic [Y_BITS-1:0] ENEMY_Y [ENEMY_COUNT_MAX] = '{
        7'd60, 7'd50, 7'd100, 7'd100, 7'd20
    };
    localparam logic [COLOR_BITS-1:0] ENEMY_COLOR [ENEMY_COUNT_MAX] = '{
        3'd1, 3'd2, 3'd3, 3'd4, 3'd5
    };

    // Enabled enemies per level, bit n is enemy n
    localparam logic [ENEMY_COUNT_MAX-1:0] LEVEL_MASK [2**LEVEL_BITS] = '{
        5'b00011,  // Level 0 falls back to level 1
        5'b00011,
        5'b00111,
        5'b11000,
        5'b11111,
        5'b00011,
        5'b00011,
        5'b00011
    };

endpackage
